/* hdl/simproc_pkg.sv */
package simproc_pkg;

    localparam int DATA_W    = 8;
    localparam int MEM_DEPTH = 256;
    localparam int NUM_REGS  = 4;
    localparam int REG_IDX_W = 2;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_OR   = 3'b010,
        ALU_NAND = 3'b011,
        ALU_SHL  = 3'b100,
        ALU_SHR  = 3'b101
    } alu_op_t;

    // Opcodes matched on all four low bits
    localparam logic [3:0] OP_LOAD  = 4'b0000;
    localparam logic [3:0] OP_JUMP  = 4'b0001;
    localparam logic [3:0] OP_STORE = 4'b0010;
    localparam logic [3:0] OP_ADD   = 4'b0100;
    localparam logic [3:0] OP_BPZ   = 4'b0101;
    localparam logic [3:0] OP_SUB   = 4'b0110;
    localparam logic [3:0] OP_NAND  = 4'b1000;
    localparam logic [3:0] OP_BNZ   = 4'b1001;
    localparam logic [3:0] OP_BZ    = 4'b1010;

    // Opcodes matched on the low three bits only
    localparam logic [2:0] OP3_SHIFT = 3'b011;
    localparam logic [2:0] OP3_ORI   = 3'b111;

    typedef struct packed {
        logic [REG_IDX_W-1:0] ra;
        logic [REG_IDX_W-1:0] rb;
        logic [3:0]           op;
    } instr_reg_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rd;
        logic                 left;
        logic [1:0]           amt;
        logic [2:0]           op3;
    } instr_shift_t;

    typedef struct packed {
        logic [4:0] imm;
        logic [2:0] op3;
    } instr_imm_t;

    typedef struct packed {
        logic signed [3:0] offset;
        logic [3:0]        op;
    } instr_br_t;

    typedef union packed {
        instr_reg_t   rr;
        instr_shift_t sh;
        instr_imm_t   im;
        instr_br_t    br;
    } instr_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        READ_REGS,
        EXEC,
        WRITE,
        ORI_WRITE
    } core_state_t;

endpackage

/* hdl/simproc_alu.sv */
module simproc_alu
    import simproc_pkg::*;
(
    input  alu_op_t             op,
    input  logic [DATA_W-1:0]   a,
    input  logic [DATA_W-1:0]   b,
    output logic [DATA_W-1:0]   y,
    output logic                n,
    output logic                z
);

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_OR:   y = a | b;
            ALU_NAND: y = ~(a & b);
            // Shift distance is limited to three places
            ALU_SHL:  y = a << b[1:0];
            ALU_SHR:  y = a >> b[1:0];
            default:  y = '0;
        endcase
    end

    assign n = y[DATA_W-1];
    assign z = (y == '0);

endmodule

/* hdl/simproc_regfile.sv */
module simproc_regfile
    import simproc_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  logic [REG_IDX_W-1:0]    wa,
    input  logic [REG_IDX_W-1:0]    ra,
    input  logic [REG_IDX_W-1:0]    rb,
    input  logic [DATA_W-1:0]       wdata,
    output logic [DATA_W-1:0]       rdata_a,
    output logic [DATA_W-1:0]       rdata_b
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wdata;
        end
    end

    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

endmodule

/* hdl/simproc_core.sv */
module simproc_core
    import simproc_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DATA_W-1:0]   mem_rdata,
    input  logic [DATA_W-1:0]   pc_set_val,
    input  logic                pc_set_wr,
    input  logic                run,
    output logic [DATA_W-1:0]   mem_addr,
    output logic [DATA_W-1:0]   mem_wdata,
    output logic                mem_we,
    output logic [DATA_W-1:0]   pc_val,
    output logic                halt,
    output logic                done
);

    core_state_t state, next_state, after_done;

    logic [DATA_W-1:0] pc, pc_next;
    instr_t            ir;
    logic [DATA_W-1:0] mdr_q, a_q, b_q, res_q;
    logic              n_flag, z_flag;

    alu_op_t           alu_op;
    logic [DATA_W-1:0] alu_a, alu_b, alu_y;
    logic              alu_n, alu_z;

    logic                 rf_we;
    logic [REG_IDX_W-1:0] rf_wa, rf_ra;
    logic [DATA_W-1:0]    rf_wdata, rf_rdata_a, rf_rdata_b;

    logic pc_wr, ir_load, ab_load, mdr_load, res_load, flag_wr, taken;

    simproc_alu u_alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y),
        .n  (alu_n),
        .z  (alu_z)
    );

    simproc_regfile u_rf (
        .clk     (clk),
        .rst     (rst),
        .we      (rf_we),
        .wa      (rf_wa),
        .ra      (rf_ra),
        .rb      (ir.rr.rb),
        .wdata   (rf_wdata),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b)
    );

    // Back-to-back instructions while run stays high
    always_comb begin
        after_done = IDLE;
        if (run) begin
            after_done = FETCH;
        end
    end

    always_comb begin
        case (ir.rr.op)
            OP_BNZ:  taken = !z_flag;
            OP_BPZ:  taken = !n_flag;
            OP_BZ:   taken = z_flag;
            default: taken = 1'b1;
        endcase
    end

    always_comb begin
        next_state = state;
        halt       = 1'b0;
        done       = 1'b0;
        pc_wr      = 1'b0;
        pc_next    = alu_y;
        alu_op     = ALU_ADD;
        alu_a      = pc;
        alu_b      = '0;
        mem_addr   = pc;
        mem_we     = 1'b0;
        ir_load    = 1'b0;
        ab_load    = 1'b0;
        mdr_load   = 1'b0;
        res_load   = 1'b0;
        flag_wr    = 1'b0;
        rf_we      = 1'b0;
        rf_wa      = ir.rr.ra;
        rf_ra      = ir.rr.ra;
        rf_wdata   = res_q;

        case (state)
            IDLE: begin
                halt = 1'b1;
                if (pc_set_wr) begin
                    pc_wr   = 1'b1;
                    pc_next = pc_set_val;
                end
                if (run) begin
                    next_state = FETCH;
                end
            end

            FETCH: begin
                ir_load    = 1'b1;
                alu_b      = DATA_W'(1);
                pc_wr      = 1'b1;
                next_state = READ_REGS;
            end

            READ_REGS: begin
                ab_load    = 1'b1;
                next_state = EXEC;
            end

            EXEC: begin
                // Undefined opcodes fall back to IDLE without done
                next_state = IDLE;
                case (ir.rr.op)
                    OP_ADD, OP_SUB, OP_NAND: begin
                        alu_a = a_q;
                        alu_b = b_q;
                        if (ir.rr.op == OP_ADD) begin
                            alu_op = ALU_ADD;
                        end else if (ir.rr.op == OP_SUB) begin
                            alu_op = ALU_SUB;
                        end else begin
                            alu_op = ALU_NAND;
                        end
                        res_load   = 1'b1;
                        flag_wr    = 1'b1;
                        next_state = WRITE;
                    end
                    OP_LOAD: begin
                        mem_addr   = b_q;
                        mdr_load   = 1'b1;
                        next_state = WRITE;
                    end
                    OP_STORE: begin
                        mem_addr   = b_q;
                        mem_we     = 1'b1;
                        done       = 1'b1;
                        next_state = after_done;
                    end
                    OP_BNZ, OP_BPZ, OP_BZ, OP_JUMP: begin
                        // PC already points past the branch
                        alu_b      = {{(DATA_W-4){ir.br.offset[3]}}, ir.br.offset};
                        pc_wr      = taken;
                        done       = 1'b1;
                        next_state = after_done;
                    end
                    default: begin
                        if (ir.sh.op3 == OP3_SHIFT) begin
                            alu_a      = a_q;
                            alu_b      = {{(DATA_W-2){1'b0}}, ir.sh.amt};
                            alu_op     = ir.sh.left ? ALU_SHL : ALU_SHR;
                            res_load   = 1'b1;
                            flag_wr    = 1'b1;
                            next_state = WRITE;
                        end else if (ir.im.op3 == OP3_ORI) begin
                            // ORI always works on r0
                            rf_ra      = '0;
                            ab_load    = 1'b1;
                            next_state = WRITE;
                        end
                    end
                endcase
            end

            WRITE: begin
                if (ir.im.op3 == OP3_ORI) begin
                    alu_a      = a_q;
                    alu_b      = {{(DATA_W-5){1'b0}}, ir.im.imm};
                    alu_op     = ALU_OR;
                    res_load   = 1'b1;
                    flag_wr    = 1'b1;
                    next_state = ORI_WRITE;
                end else begin
                    rf_we      = 1'b1;
                    rf_wdata   = (ir.rr.op == OP_LOAD) ? mdr_q : res_q;
                    done       = 1'b1;
                    next_state = after_done;
                end
            end

            ORI_WRITE: begin
                rf_wa      = '0;
                rf_we      = 1'b1;
                done       = 1'b1;
                next_state = after_done;
            end

            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            pc     <= '0;
            n_flag <= 1'b0;
            z_flag <= 1'b0;
        end else begin
            state <= next_state;
            if (pc_wr) begin
                pc <= pc_next;
            end
            if (flag_wr) begin
                n_flag <= alu_n;
                z_flag <= alu_z;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= mem_rdata;
        end
        if (mdr_load) begin
            mdr_q <= mem_rdata;
        end
        if (ab_load) begin
            a_q <= rf_rdata_a;
            b_q <= rf_rdata_b;
        end
        if (res_load) begin
            res_q <= alu_y;
        end
    end

    assign mem_wdata = a_q;
    assign pc_val    = pc;

endmodule

/* hdl/dp_ram.sv */
module dp_ram
    import simproc_pkg::*;
(
    input  logic                clk,
    input  logic [DATA_W-1:0]   addr_a,
    input  logic [DATA_W-1:0]   wdata_a,
    input  logic                we_a,
    input  logic [DATA_W-1:0]   addr_b,
    input  logic [DATA_W-1:0]   wdata_b,
    input  logic                we_b,
    output logic [DATA_W-1:0]   rdata_a,
    output logic [DATA_W-1:0]   rdata_b
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    // Port B is written last so it wins on a collision
    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        if (we_b) begin
            mem[addr_b] <= wdata_b;
        end
    end

    assign rdata_a = mem[addr_a];
    assign rdata_b = mem[addr_b];

endmodule

/* hdl/simproc_system.sv */
module simproc_system
    import simproc_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DATA_W-1:0]   ram_addr,
    input  logic [DATA_W-1:0]   ram_wdata,
    input  logic                ram_we,
    input  logic [DATA_W-1:0]   pc_set_val,
    input  logic                pc_set_wr,
    input  logic                run,
    output logic [DATA_W-1:0]   ram_rdata,
    output logic [DATA_W-1:0]   pc_val,
    output logic                halt,
    output logic                done
);

    // Core side of the RAM
    logic [DATA_W-1:0] mem_addr, mem_wdata, mem_rdata;
    logic              mem_we;

    simproc_core u_core (
        .clk        (clk),
        .rst        (rst),
        .mem_rdata  (mem_rdata),
        .pc_set_val (pc_set_val),
        .pc_set_wr  (pc_set_wr),
        .run        (run),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .pc_val     (pc_val),
        .halt       (halt),
        .done       (done)
    );

    dp_ram u_ram (
        .clk     (clk),
        .addr_a  (mem_addr),
        .wdata_a (mem_wdata),
        .we_a    (mem_we),
        .addr_b  (ram_addr),
        .wdata_b (ram_wdata),
        .we_b    (ram_we),
        .rdata_a (mem_rdata),
        .rdata_b (ram_rdata)
    );

endmodule

/* tb/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

/* tb/simproc_chk.sv */
module simproc_chk (
    input logic clk,
    input logic rst,
    input logic run,
    input logic mem_we,
    input logic halt,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    halt_done_excl: assert property (@(posedge clk) disable iff (rst) !(halt && done))
        else begin
            $error("halt and done were high in the same cycle");
            fail_count++;
        end

    // Memory writes only happen inside an instruction
    we_not_halted: assert property (@(posedge clk) disable iff (rst) mem_we |-> !halt)
        else begin
            $error("mem_we was high while the core was halted");
            fail_count++;
        end

    done_single: assert property (@(posedge clk) disable iff (rst) (done && !run) |=> !done)
        else begin
            $error("done stayed high for two cycles with run low");
            fail_count++;
        end

    halt_after_reset: assert property (@(posedge clk) $fell(rst) |-> halt)
        else begin
            $error("core was not halted right after reset");
            fail_count++;
        end

endmodule

bind simproc_core simproc_chk u_chk (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .mem_we (mem_we),
    .halt   (halt),
    .done   (done)
);

/* tb/simproc_tb.sv */
module simproc_tb
    import simproc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES  = 16;
    localparam int STEP_COUNT  = 40;
    localparam int RUN_MAX     = 60;
    localparam int BR_STEPS    = 17;
    localparam int UNDEF_STEPS = 6;
    // Run mode may hit undefined opcodes between done pulses
    localparam int INSTR_MAX   = STEP_COUNT + 2 * RUN_MAX + BR_STEPS + UNDEF_STEPS;
    localparam int CYCLE_LIMIT = RST_CYCLES + 4 * MEM_DEPTH + 7 * INSTR_MAX + 100;
    localparam logic [DATA_W-1:0] BR_BASE    = 8'h80;
    localparam logic [DATA_W-1:0] UNDEF_BASE = 8'h60;

    logic              clk, rst;
    logic [DATA_W-1:0] ram_addr, ram_wdata, ram_rdata;
    logic [DATA_W-1:0] pc_set_val, pc_val;
    logic              ram_we, pc_set_wr, run, halt, done;

    // Reference model state
    logic [DATA_W-1:0] m_mem [MEM_DEPTH];
    logic [DATA_W-1:0] m_regs [NUM_REGS];
    logic [DATA_W-1:0] m_pc;
    logic              m_n, m_z;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;
    int unsigned done_cnt = 0;
    int unsigned undef_cnt = 0;
    logic        halt_prev = 1'b1;
    logic        done_prev = 1'b0;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    simproc_system uut (
        .clk        (clk),
        .rst        (rst),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_we     (ram_we),
        .pc_set_val (pc_set_val),
        .pc_set_wr  (pc_set_wr),
        .run        (run),
        .ram_rdata  (ram_rdata),
        .pc_val     (pc_val),
        .halt       (halt),
        .done       (done)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // An undefined opcode shows up as a return to IDLE without done
    always @(negedge clk) begin
        if (!rst) begin
            if (done) begin
                done_cnt++;
            end
            if (halt && !halt_prev && !done_prev) begin
                undef_cnt++;
            end
        end
        halt_prev = halt;
        done_prev = done;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    function automatic logic [7:0] random_instr();
        logic [7:0] v;
        v = 8'($urandom);
        while (v[3:0] inside {4'b1100, 4'b1101, 4'b1110}) begin
            v = 8'($urandom);
        end
        return v;
    endfunction

    function automatic logic [7:0] reg_instr(input logic [1:0] ra, input logic [1:0] rb,
                                             input logic [3:0] op);
        return {ra, rb, op};
    endfunction

    function automatic logic [7:0] branch_instr(input int offset, input logic [3:0] op);
        return {4'(offset), op};
    endfunction

    task automatic model_exec(output bit defined);
        instr_t            ins;
        logic [DATA_W-1:0] a, b, res, offset;
        logic [1:0]        dest;
        ins     = m_mem[m_pc];
        m_pc    = m_pc + 8'd1;
        a       = m_regs[ins.rr.ra];
        b       = m_regs[ins.rr.rb];
        offset  = {{4{ins.br.offset[3]}}, ins.br.offset};
        dest    = ins.rr.ra;
        res     = '0;
        defined = 1'b1;
        case (ins.rr.op)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_NAND:  res = ~(a & b);
            OP_LOAD:  m_regs[dest] = m_mem[b];
            OP_STORE: m_mem[b] = a;
            OP_BNZ:   m_pc = m_z ? m_pc : m_pc + offset;
            OP_BPZ:   m_pc = m_n ? m_pc : m_pc + offset;
            OP_BZ:    m_pc = m_z ? m_pc + offset : m_pc;
            OP_JUMP:  m_pc = m_pc + offset;
            default:  defined = 1'b0;
        endcase
        // Shift and ORI decode on the low three bits
        if (ins.sh.op3 == OP3_SHIFT) begin
            res     = ins.sh.left ? a << ins.sh.amt : a >> ins.sh.amt;
            defined = 1'b1;
        end else if (ins.im.op3 == OP3_ORI) begin
            res     = m_regs[0] | {3'b000, ins.im.imm};
            dest    = 2'd0;
            defined = 1'b1;
        end
        if (ins.rr.op inside {OP_ADD, OP_SUB, OP_NAND} || ins.sh.op3 == OP3_SHIFT
                || ins.im.op3 == OP3_ORI) begin
            m_regs[dest] = res;
            m_n          = res[DATA_W-1];
            m_z          = (res == '0);
        end
    endtask

    task automatic write_ram(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
        ram_addr  = addr;
        ram_wdata = data;
        ram_we    = 1'b1;
        @(posedge clk);
        #5;
        ram_we      = 1'b0;
        m_mem[addr] = data;
    endtask

    task automatic read_ram(input logic [DATA_W-1:0] addr, output logic [DATA_W-1:0] data);
        ram_addr = addr;
        @(negedge clk);
        data = ram_rdata;
        @(posedge clk);
        #5;
    endtask

    task automatic compare_memory(input string name);
        logic [DATA_W-1:0] data;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            read_ram(DATA_W'(i), data);
            check_value($sformatf("%s[%0d]", name, i), m_mem[i], data);
            check_value({name, " halt"}, 1, halt);
        end
    endtask

    task automatic set_pc(input logic [DATA_W-1:0] value);
        pc_set_val = value;
        pc_set_wr  = 1'b1;
        @(posedge clk);
        #5;
        pc_set_wr = 1'b0;
        m_pc      = value;
        @(negedge clk);
        check_value("pc set", value, pc_val);
        @(posedge clk);
        #5;
    endtask

    task automatic wait_halt();
        do begin
            @(negedge clk);
            #1;
        end while (!halt);
        @(posedge clk);
        #5;
    endtask

    task automatic step_one(input string name);
        int unsigned d0;
        bit          defined;
        d0  = done_cnt;
        run = 1'b1;
        @(posedge clk);
        #5;
        run = 1'b0;
        wait_halt();
        model_exec(defined);
        check_value({name, " done count"}, 32'(defined), done_cnt - d0);
        check_value({name, " pc"}, m_pc, pc_val);
    endtask

    task automatic run_burst(input int unsigned k);
        int unsigned d0, u0, n, n_def;
        bit          defined;
        d0  = done_cnt;
        u0  = undef_cnt;
        run = 1'b1;
        do begin
            @(negedge clk);
            #1;
        end while (done_cnt - d0 < k);
        @(posedge clk);
        #5;
        run = 1'b0;
        wait_halt();
        n_def = 0;
        n     = (done_cnt - d0) + (undef_cnt - u0);
        for (int i = 0; i < n; i++) begin
            model_exec(defined);
            n_def += 32'(defined);
        end
        check_value("run done count", n_def, done_cnt - d0);
        check_value("run pc", m_pc, pc_val);
    endtask

    initial begin
        int unsigned asserts;
        void'($urandom(32'h700d_09f9));
        rst        = 1'b1;
        run        = 1'b0;
        pc_set_wr  = 1'b0;
        pc_set_val = '0;
        ram_we     = 1'b0;
        ram_addr   = '0;
        ram_wdata  = '0;
        m_pc       = '0;
        m_n        = 1'b0;
        m_z        = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;

        // Random bytes that are also a program of defined opcodes
        for (int i = 0; i < MEM_DEPTH; i++) begin
            write_ram(DATA_W'(i), random_instr());
        end
        compare_memory("readback");

        set_pc(DATA_W'($urandom));
        for (int i = 0; i < STEP_COUNT; i++) begin
            step_one("step");
        end

        run_burst($urandom_range(RUN_MAX, 20));
        compare_memory("run dump");

        // Slots 2 3 7 8 16 19 of the branch program are never reached
        write_ram(BR_BASE + 8'd0, reg_instr(2'd1, 2'd1, OP_SUB));
        write_ram(BR_BASE + 8'd1, branch_instr(2, OP_BZ));
        write_ram(BR_BASE + 8'd4, branch_instr(3, OP_BNZ));
        write_ram(BR_BASE + 8'd5, {5'h11, OP3_ORI});
        write_ram(BR_BASE + 8'd6, branch_instr(2, OP_BNZ));
        write_ram(BR_BASE + 8'd9, reg_instr(2'd2, 2'd2, OP_SUB));
        write_ram(BR_BASE + 8'd10, reg_instr(2'd2, 2'd2, OP_NAND));
        write_ram(BR_BASE + 8'd11, branch_instr(3, OP_BPZ));
        write_ram(BR_BASE + 8'd12, branch_instr(-4, OP_BZ));
        write_ram(BR_BASE + 8'd13, branch_instr(3, OP_JUMP));
        write_ram(BR_BASE + 8'd14, reg_instr(2'd2, 2'd1, OP_STORE));
        write_ram(BR_BASE + 8'd15, branch_instr(4, OP_JUMP));
        write_ram(BR_BASE + 8'd17, reg_instr(2'd3, 2'd3, OP_SUB));
        write_ram(BR_BASE + 8'd18, branch_instr(-5, OP_BPZ));
        write_ram(BR_BASE + 8'd20, reg_instr(2'd0, 2'd2, OP_STORE));
        write_ram(BR_BASE + 8'd21, {2'd0, 1'b1, 2'd1, OP3_SHIFT});
        write_ram(BR_BASE + 8'd22, reg_instr(2'd0, 2'd1, OP_STORE));
        set_pc(BR_BASE);
        for (int i = 0; i < BR_STEPS; i++) begin
            step_one("branch");
        end
        compare_memory("branch dump");

        for (int i = 0; i < UNDEF_STEPS; i++) begin
            write_ram(UNDEF_BASE + DATA_W'(i), {4'($urandom), 4'b1100 + 4'(i % 3)});
        end
        set_pc(UNDEF_BASE);
        for (int i = 0; i < UNDEF_STEPS; i++) begin
            step_one("undefined");
        end

        asserts = uut.u_core.u_chk.fail_count;
        $display("%0d checks, %0d mismatches, %0d assertion failures", checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/simproc_pkg.sv
hdl/simproc_alu.sv
hdl/simproc_regfile.sv
hdl/simproc_core.sv
hdl/dp_ram.sv
hdl/simproc_system.sv
tb/tb_clk_gen.sv
tb/simproc_chk.sv
tb/simproc_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = simproc_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
